// ==== bench/tb_model.svh ====
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

logic [31:0] lfsr_state;
word_t       arch_regs [ARCH_REGS];   // x0 is never written
int          checks;
int          errors;

// fibonacci lfsr, taps 32 22 2 1
function automatic logic lfsr_bit();
    logic fb;
    fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    lfsr_state = {lfsr_state[30:0], fb};
    return fb;
endfunction

function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
        v = {v[30:0], lfsr_bit()};   // one step per bit
    end
    return v;
endfunction

// sequential meaning of each opcode
function automatic word_t ref_exec(input opcode_e op, input word_t a, input word_t b,
                                   input word_t imm);
    case (op)
        OP_ADD:  return a + b;
        OP_SUB:  return a - b;
        OP_AND:  return a & b;
        OP_OR:   return a | b;
        OP_XOR:  return a ^ b;
        OP_ADDI: return a + imm;
        OP_MUL:  return a * b;   // low 32 bits only
        default: return 'x;
    endcase
endfunction

function automatic word_t apply_model(input uop_t u);
    word_t value;
    value = ref_exec(u.opcode, arch_regs[u.rs1], arch_regs[u.rs2], u.imm);
    if (u.rd != '0) begin
        arch_regs[u.rd] = value;
    end
    return value;
endfunction

task automatic check_value(input string what, input word_t got, input word_t exp);
    checks++;
    if (got !== exp) begin
        errors++;
        $display("[FAIL] %0t ns: %s is %h, expected %h", $time, what, got, exp);
    end
endtask

`endif

// ==== bench/tb_ooo_core.sv ====
`timescale 1ns/1ns

module tb_ooo_core
import core_cfg_pkg::*, uop_pkg::*;
();

    localparam int WAIT_LIMIT = 2000;   // cycles per wait loop

    logic    clk;
    logic    rst;
    logic    uop_valid;
    uop_t    uop;
    logic    credit;
    commit_t commit;

    commit_t exp_q [$];    // expected commits in program order
    int      credits;      // credits held by the stimulus side
    int      credits_back;
    int      sent;
    int      commits;
    int      tests;
    int      failed_tests;
    logic    timed_out;

    `include "tb_model.svh"

    ooo_core i_ooo_core (
        .clk(clk),
        .rst(rst),
        .uop_valid_i(uop_valid),
        .uop_i(uop),
        .credit_o(credit),
        .commit_o(commit)
    );

    always #2 clk = ~clk;

    // credit return and commit compare, sampled mid-cycle
    always @(negedge clk) begin : commit_monitor
        commit_t exp;
        if (!rst) begin
            if (credit) begin
                credits++;
                credits_back++;
            end
            if (commit.valid) begin
                commits++;
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("error at %0t ns: a commit arrived with no uop outstanding", $time);
                end else begin
                    exp = exp_q.pop_front();
                    check_value("commit rd", word_t'(commit.rd), word_t'(exp.rd));
                    check_value("commit value", commit.value, exp.value);
                end
            end
        end
    end

    function automatic uop_t make_uop(input opcode_e op, input arch_reg_t rd,
                                      input arch_reg_t rs1, input arch_reg_t rs2,
                                      input word_t imm);
        uop_t u;
        u.opcode = op;
        u.rd     = rd;
        u.rs1    = rs1;
        u.rs2    = rs2;
        u.imm    = imm;
        return u;
    endfunction

    function automatic uop_t random_uop();
        uop_t u;
        if (rand_bits(2) == 0) begin   // about a quarter multiplies
            u.opcode = OP_MUL;
        end else begin
            u.opcode = opcode_e'(rand_bits(3) % 6);
        end
        u.rd  = arch_reg_t'(rand_bits(5));
        u.rs1 = arch_reg_t'(rand_bits(5));
        u.rs2 = arch_reg_t'(rand_bits(5));
        u.imm = rand_bits(32);
        return u;
    endfunction

    task automatic idle_cycle();
        @(posedge clk);
        uop_valid <= 1'b0;
    endtask

    task automatic send_uop(input uop_t u);
        int      waited;
        word_t   value;
        commit_t rec;
        waited = 0;
        while (credits == 0 && !timed_out) begin
            idle_cycle();
            waited++;
            if (waited > WAIT_LIMIT) begin
                errors++;
                timed_out = 1'b1;
                $display("timeout: no credit came back from the core");
            end
        end
        if (!timed_out) begin
            @(posedge clk);
            uop_valid <= 1'b1;
            uop       <= u;
            credits--;
            sent++;
            value     = apply_model(u);
            rec.valid = 1'b1;
            rec.rd    = u.rd;
            rec.value = value;
            exp_q.push_back(rec);
        end
    endtask

    // wait until every sent uop has committed
    task automatic wait_drain();
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && !timed_out) begin
            idle_cycle();
            waited++;
            if (waited > WAIT_LIMIT) begin
                errors++;
                timed_out = 1'b1;
                $display("timeout: %0d uops never committed", exp_q.size());
            end
        end
    endtask

    task automatic finish_test(input string name, input int err_before);
        tests++;
        if (errors != err_before) begin
            failed_tests++;
        end
        $display("test %-18s %s", name, (errors == err_before) ? "ok" : "has errors");
    endtask

    task automatic quiet_after_reset();
        int err_before;
        err_before = errors;
        repeat (16) begin
            @(negedge clk);
            check_value("credit_o while idle", word_t'(credit), '0);
            check_value("commit valid while idle", word_t'(commit.valid), '0);
        end
        @(posedge clk);
        finish_test("reset_state", err_before);
    endtask

    task automatic independent_ops();
        int err_before;
        err_before = errors;
        send_uop(make_uop(OP_ADDI, 1, 0, 0, 32'h1234_5678));
        send_uop(make_uop(OP_ADDI, 2, 0, 0, 32'h0000_00ff));
        send_uop(make_uop(OP_ADDI, 3, 0, 0, 32'hf0f0_0f0f));
        send_uop(make_uop(OP_ADDI, 4, 0, 0, 32'h0000_1001));
        send_uop(make_uop(OP_ADDI, 5, 0, 0, 32'h8000_0003));
        send_uop(make_uop(OP_ADDI, 6, 0, 0, 32'hffff_fffd));   // -3
        send_uop(make_uop(OP_ADD, 10, 1, 2, '0));
        send_uop(make_uop(OP_SUB, 11, 3, 4, '0));
        send_uop(make_uop(OP_AND, 12, 1, 5, '0));
        send_uop(make_uop(OP_OR, 13, 2, 6, '0));
        send_uop(make_uop(OP_XOR, 14, 3, 5, '0));
        send_uop(make_uop(OP_ADDI, 15, 4, 0, 32'hffff_fff9));
        send_uop(make_uop(OP_MUL, 16, 5, 6, '0));
        wait_drain();
        finish_test("independent_ops", err_before);
    endtask

    task automatic dependency_chains();
        int err_before;
        err_before = errors;
        send_uop(make_uop(OP_ADDI, 7, 0, 0, 32'd3));
        for (int i = 0; i < 6; i++) begin   // everything through x7
            send_uop(make_uop(OP_MUL, 7, 7, 2, '0));
            send_uop(make_uop(OP_ADD, 7, 7, 1, '0));
            send_uop(make_uop(OP_XOR, 7, 7, 3, '0));
        end
        send_uop(make_uop(OP_MUL, 8, 1, 2, '0));
        send_uop(make_uop(OP_ADD, 9, 8, 8, '0));
        send_uop(make_uop(OP_SUB, 9, 9, 8, '0));
        send_uop(make_uop(OP_AND, 9, 9, 1, '0));
        // younger simple ops finish first but must commit after the multiply
        send_uop(make_uop(OP_MUL, 20, 3, 4, '0));
        send_uop(make_uop(OP_ADDI, 21, 1, 0, 32'd1));
        send_uop(make_uop(OP_OR, 22, 2, 3, '0));
        send_uop(make_uop(OP_XOR, 23, 4, 5, '0));
        send_uop(make_uop(OP_SUB, 24, 6, 1, '0));
        wait_drain();
        finish_test("dependency_chains", err_before);
    endtask

    task automatic register_zero();
        int err_before;
        err_before = errors;
        send_uop(make_uop(OP_ADDI, 0, 1, 0, 32'd5));
        send_uop(make_uop(OP_ADD, 17, 0, 2, '0));
        send_uop(make_uop(OP_MUL, 0, 3, 3, '0));
        send_uop(make_uop(OP_OR, 18, 0, 0, '0));
        send_uop(make_uop(OP_ADDI, 19, 0, 0, 32'd9));
        wait_drain();
        finish_test("register_zero", err_before);
    endtask

    task automatic long_random_run();
        int err_before;
        err_before = errors;
        for (int n = 0; n < 2000 && !timed_out; n++) begin
            if (rand_bits(3) == 0) begin   // upstream pause
                repeat (rand_bits(2) + 1) idle_cycle();
            end
            send_uop(random_uop());
        end
        wait_drain();
        check_value("uops committed", commits, sent);
        check_value("credits returned", credits_back, sent);
        finish_test("random_run", err_before);
    endtask

    initial begin
        clk          = 1'b0;
        rst          = 1'b1;
        uop_valid    = 1'b0;
        uop          = '0;
        lfsr_state   = 32'hd346_02bd;
        credits      = INTAKE_CREDITS;
        credits_back = 0;
        sent         = 0;
        commits      = 0;
        tests        = 0;
        failed_tests = 0;
        checks       = 0;
        errors       = 0;
        timed_out    = 1'b0;
        for (int r = 0; r < ARCH_REGS; r++) begin
            arch_regs[r] = '0;
        end
        repeat (3) @(posedge clk);
        rst <= 1'b0;

        quiet_after_reset();
        independent_ops();
        dependency_chains();
        register_zero();
        long_random_run();

        $display("tests %0d, failed %0d, checks %0d, errors %0d, uops %0d, commits %0d",
                 tests, failed_tests, checks, errors, sent, commits);
        if (errors == 0 && !timed_out) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// ==== rtl/core_cfg_pkg.sv ====
package core_cfg_pkg;

    // machine sizing
    localparam int ARCH_REGS      = 32;
    localparam int PHYS_REGS      = 64;
    localparam int FREE_REGS      = PHYS_REGS - ARCH_REGS; // renamable pool
    localparam int ROB_DEPTH      = 16;
    localparam int RS_DEPTH       = 8;
    localparam int INTAKE_CREDITS = 4;  // also upstream's starting credit count
    localparam int MUL_STAGES     = 3;
    localparam int XLEN           = 32;

    typedef logic [$clog2(ARCH_REGS)-1:0]      arch_reg_t;
    typedef logic [$clog2(PHYS_REGS)-1:0]      phys_reg_t;
    typedef logic [$clog2(ROB_DEPTH)-1:0]      rob_idx_t;
    typedef logic [$clog2(ROB_DEPTH):0]        rob_cnt_t;
    typedef logic [$clog2(RS_DEPTH)-1:0]       rs_idx_t;
    typedef logic [$clog2(RS_DEPTH):0]         rs_cnt_t;
    typedef logic [$clog2(FREE_REGS)-1:0]      fl_idx_t;
    typedef logic [$clog2(FREE_REGS):0]        fl_cnt_t;
    typedef logic [$clog2(INTAKE_CREDITS)-1:0] ib_idx_t;
    typedef logic [$clog2(INTAKE_CREDITS):0]   credit_cnt_t;
    typedef logic [XLEN-1:0]                   word_t;

endpackage

// ==== rtl/exec_unit.sv ====
`timescale 1ns/1ns

module exec_unit
import core_cfg_pkg::*, uop_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    issue_valid_i,
    input  issue_t  issue_i,
    output logic    simple_ok_o,
    output result_t result_o
);

    typedef struct packed {
        logic        valid;
        phys_reg_t   pd;
        rob_idx_t    rob;
        word_t       lo;   // a * b[15:0]
        logic [15:0] hi;   // low half of a[15:0] * b[31:16]
    } mul_stage_t;

    mul_stage_t mul_q [MUL_STAGES-1];
    logic       simple_fire;
    word_t      simple_value;
    word_t      mul_value;

    assign simple_fire = issue_valid_i && issue_i.opcode != OP_MUL;
    assign simple_ok_o = !mul_q[MUL_STAGES-2].valid;  // that multiply owns the next bus slot
    assign mul_value   = mul_q[MUL_STAGES-2].lo + {mul_q[MUL_STAGES-2].hi, 16'h0000};

    always_comb begin
        case (issue_i.opcode)
            OP_SUB:  simple_value = issue_i.op_a - issue_i.op_b;
            OP_AND:  simple_value = issue_i.op_a & issue_i.op_b;
            OP_OR:   simple_value = issue_i.op_a | issue_i.op_b;
            OP_XOR:  simple_value = issue_i.op_a ^ issue_i.op_b;
            default: simple_value = issue_i.op_a + issue_i.op_b;  // add, addi
        endcase
    end

    always_ff @(posedge clk) begin
        mul_q[0].valid <= issue_valid_i && issue_i.opcode == OP_MUL;
        mul_q[0].pd    <= issue_i.pd;
        mul_q[0].rob   <= issue_i.rob;
        mul_q[0].lo    <= issue_i.op_a * issue_i.op_b[15:0];
        mul_q[0].hi    <= issue_i.op_a[15:0] * issue_i.op_b[31:16];
        for (int s = 1; s < MUL_STAGES - 1; s++) begin
            mul_q[s] <= mul_q[s - 1];
        end
        if (mul_q[MUL_STAGES-2].valid) begin
            result_o <= {1'b1, mul_q[MUL_STAGES-2].pd, mul_q[MUL_STAGES-2].rob, mul_value};
        end else begin
            result_o <= {simple_fire, issue_i.pd, issue_i.rob, simple_value};
        end
        if (rst) begin
            for (int s = 0; s < MUL_STAGES - 1; s++) begin
                mul_q[s].valid <= 1'b0;
            end
            result_o.valid <= 1'b0;
        end
    end

    // the station has to hold simple ops back behind a finishing multiply
    a_single_finisher: assert property (@(posedge clk) disable iff (rst)
        !(simple_fire && mul_q[MUL_STAGES-2].valid));

endmodule

// ==== rtl/ooo_core.sv ====
`timescale 1ns/1ns

module ooo_core
import core_cfg_pkg::*, uop_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    uop_valid_i,
    input  uop_t    uop_i,
    output logic    credit_o,
    output commit_t commit_o
);

    renamed_uop_t    dispatch;
    logic            dispatch_valid;
    arch_reg_t       dispatch_rd;
    phys_reg_t       stale_pd;
    logic            rob_alloc_ok;
    logic            rs_alloc_ok;
    rob_idx_t        rob_idx;
    logic            free_valid;
    phys_reg_t       free_pd;
    phys_reg_t [1:0] src_sel;
    logic [1:0]      src_ready;
    word_t [1:0]     src_value;
    logic            simple_ok;
    logic            issue_valid;
    issue_t          issue;
    result_t         result;   // shared result bus

    rename_unit i_rename_unit (
        .clk(clk), .rst(rst),
        .uop_valid_i(uop_valid_i), .uop_i(uop_i), .credit_o(credit_o),
        .rob_alloc_ok_i(rob_alloc_ok), .rs_alloc_ok_i(rs_alloc_ok), .rob_idx_i(rob_idx),
        .dispatch_o(dispatch), .dispatch_valid_o(dispatch_valid),
        .dispatch_rd_o(dispatch_rd), .stale_pd_o(stale_pd),
        .free_valid_i(free_valid), .free_pd_i(free_pd)
    );

    reservation_station i_reservation_station (
        .clk(clk), .rst(rst),
        .dispatch_valid_i(dispatch_valid), .dispatch_i(dispatch),
        .rs_alloc_ok_o(rs_alloc_ok),
        .src_ready_i(src_ready), .src_value_i(src_value), .src_sel_o(src_sel),
        .result_i(result), .simple_ok_i(simple_ok),
        .issue_valid_o(issue_valid), .issue_o(issue)
    );

    phys_regfile i_phys_regfile (
        .clk(clk), .rst(rst),
        .dispatch_valid_i(dispatch_valid), .alloc_pd_i(dispatch.pd),
        .rd_sel_i(src_sel), .rd_ready_o(src_ready), .rd_value_o(src_value),
        .result_i(result)
    );

    exec_unit i_exec_unit (
        .clk(clk), .rst(rst),
        .issue_valid_i(issue_valid), .issue_i(issue),
        .simple_ok_o(simple_ok), .result_o(result)
    );

    reorder_buffer i_reorder_buffer (
        .clk(clk), .rst(rst),
        .dispatch_valid_i(dispatch_valid), .dispatch_rd_i(dispatch_rd),
        .stale_pd_i(stale_pd),
        .rob_alloc_ok_o(rob_alloc_ok), .rob_idx_o(rob_idx),
        .result_i(result), .commit_o(commit_o),
        .free_valid_o(free_valid), .free_pd_o(free_pd)
    );

endmodule

// ==== rtl/phys_regfile.sv ====
`timescale 1ns/1ns

module phys_regfile
import core_cfg_pkg::*, uop_pkg::*;
(
    input  logic            clk,
    input  logic            rst,
    input  logic            dispatch_valid_i,
    input  phys_reg_t       alloc_pd_i,
    input  phys_reg_t [1:0] rd_sel_i,
    output logic [1:0]      rd_ready_o,
    output word_t [1:0]     rd_value_o,
    input  result_t         result_i
);

    word_t                regs [PHYS_REGS];
    logic [PHYS_REGS-1:0] ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            ready <= '1;
            for (int i = 0; i < PHYS_REGS; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (dispatch_valid_i && alloc_pd_i != '0) begin
                ready[alloc_pd_i] <= 1'b0;   // pending until the result bus
            end
            // register 0 is never written
            if (result_i.valid && result_i.pd != '0) begin
                ready[result_i.pd] <= 1'b1;
                regs[result_i.pd]  <= result_i.value;
            end
        end
    end

    always_comb begin
        for (int p = 0; p < 2; p++) begin
            rd_ready_o[p] = ready[rd_sel_i[p]];
            rd_value_o[p] = regs[rd_sel_i[p]];
        end
    end

endmodule

// ==== rtl/rename_unit.sv ====
`timescale 1ns/1ns

module rename_unit
import core_cfg_pkg::*, uop_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  logic         uop_valid_i,
    input  uop_t         uop_i,
    output logic         credit_o,
    input  logic         rob_alloc_ok_i,
    input  logic         rs_alloc_ok_i,
    input  rob_idx_t     rob_idx_i,
    output renamed_uop_t dispatch_o,
    output logic         dispatch_valid_o,
    output arch_reg_t    dispatch_rd_o,
    output phys_reg_t    stale_pd_o,
    input  logic         free_valid_i,
    input  phys_reg_t    free_pd_i
);

    uop_t        ib_mem [INTAKE_CREDITS];
    ib_idx_t     ib_wr;
    ib_idx_t     ib_rd;
    credit_cnt_t ib_cnt;
    uop_t        head;

    phys_reg_t   rat [ARCH_REGS];

    phys_reg_t   fl_mem [FREE_REGS];
    fl_idx_t     fl_head;
    fl_idx_t     fl_tail;
    fl_cnt_t     fl_cnt;

    logic        take;
    logic        need_pd;
    phys_reg_t   new_pd;

    assign head    = ib_mem[ib_rd];
    assign need_pd = head.rd != '0;     // x0 keeps physical 0
    assign take    = (ib_cnt != '0) && rob_alloc_ok_i && rs_alloc_ok_i
                     && (fl_cnt != '0 || !need_pd);
    assign new_pd  = need_pd ? fl_mem[fl_head] : '0;

    assign credit_o         = take;   // one credit back per uop leaving
    assign dispatch_valid_o = take;
    assign dispatch_rd_o    = head.rd;
    assign stale_pd_o       = rat[head.rd];

    always_comb begin
        dispatch_o.opcode = head.opcode;
        dispatch_o.pd     = new_pd;
        dispatch_o.ps1    = rat[head.rs1];
        dispatch_o.ps2    = (head.opcode == OP_ADDI) ? '0 : rat[head.rs2]; // no false dep
        dispatch_o.imm    = head.imm;
        dispatch_o.rob    = rob_idx_i;
    end

    always_ff @(posedge clk) begin
        if (uop_valid_i) begin
            ib_mem[ib_wr] <= uop_i;
        end
        if (rst) begin
            ib_wr  <= '0;
            ib_rd  <= '0;
            ib_cnt <= '0;
        end else begin
            if (uop_valid_i) begin
                ib_wr <= ib_wr + 1'b1;
            end
            if (take) begin
                ib_rd <= ib_rd + 1'b1;
            end
            ib_cnt <= ib_cnt + credit_cnt_t'(uop_valid_i) - credit_cnt_t'(take);
        end
    end

    // alias table, identity map out of reset
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < ARCH_REGS; i++) begin
                rat[i] <= phys_reg_t'(i);
            end
        end else if (take && need_pd) begin
            rat[head.rd] <= new_pd;
        end
    end

    // circular free list, starts full with the upper half
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < FREE_REGS; i++) begin
                fl_mem[i] <= phys_reg_t'(ARCH_REGS + i);
            end
            fl_head <= '0;
            fl_tail <= '0;
            fl_cnt  <= fl_cnt_t'(FREE_REGS);
        end else begin
            if (free_valid_i) begin
                fl_mem[fl_tail] <= free_pd_i;
                fl_tail         <= fl_tail + 1'b1;
            end
            if (take && need_pd) begin
                fl_head <= fl_head + 1'b1;
            end
            fl_cnt <= fl_cnt + fl_cnt_t'(free_valid_i) - fl_cnt_t'(take && need_pd);
        end
    end

    // upstream credit accounting must keep the buffer from overflowing
    a_intake_no_overflow: assert property (@(posedge clk) disable iff (rst)
        uop_valid_i |-> ib_cnt != credit_cnt_t'(INTAKE_CREDITS));

    // a double free from the ROB pushes the count past the pool size
    a_free_list_in_range: assert property (@(posedge clk) disable iff (rst)
        fl_cnt <= fl_cnt_t'(FREE_REGS));

endmodule

// ==== rtl/reorder_buffer.sv ====
`timescale 1ns/1ns

module reorder_buffer
import core_cfg_pkg::*, uop_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      dispatch_valid_i,
    input  arch_reg_t dispatch_rd_i,
    input  phys_reg_t stale_pd_i,
    output logic      rob_alloc_ok_o,
    output rob_idx_t  rob_idx_o,
    input  result_t   result_i,
    output commit_t   commit_o,
    output logic      free_valid_o,
    output phys_reg_t free_pd_o
);

    arch_reg_t            rd_mem    [ROB_DEPTH];
    phys_reg_t            stale_mem [ROB_DEPTH];
    word_t                value_mem [ROB_DEPTH];
    logic [ROB_DEPTH-1:0] done;
    rob_idx_t             head;
    rob_idx_t             tail;
    rob_cnt_t             cnt;
    logic                 commit;

    assign rob_alloc_ok_o = cnt != rob_cnt_t'(ROB_DEPTH);
    assign rob_idx_o      = tail;

    // in-order retire of the head once its result is in
    assign commit         = cnt != '0 && done[head];
    assign commit_o.valid = commit;
    assign commit_o.rd    = rd_mem[head];
    assign commit_o.value = value_mem[head];
    assign free_valid_o   = commit && rd_mem[head] != '0;
    assign free_pd_o      = stale_mem[head];

    always_ff @(posedge clk) begin
        if (dispatch_valid_i) begin
            rd_mem[tail]    <= dispatch_rd_i;
            stale_mem[tail] <= stale_pd_i;  // previous mapping of rd
        end
        if (result_i.valid) begin
            value_mem[result_i.rob] <= result_i.value;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            head <= '0;
            tail <= '0;
            cnt  <= '0;
            done <= '0;
        end else begin
            if (dispatch_valid_i) begin
                done[tail] <= 1'b0;
                tail       <= tail + 1'b1;
            end
            if (result_i.valid) begin
                done[result_i.rob] <= 1'b1;
            end
            if (commit) begin
                head <= head + 1'b1;
            end
            cnt <= cnt + rob_cnt_t'(dispatch_valid_i) - rob_cnt_t'(commit);
        end
    end

    // a completion on a free slot would let its next occupant retire unfinished
    a_commit_done: assert property (@(posedge clk) disable iff (rst)
        result_i.valid |-> rob_cnt_t'(rob_idx_t'(result_i.rob - head)) < cnt);

    // each uop should reach the result bus exactly once
    a_single_completion: assert property (@(posedge clk) disable iff (rst)
        result_i.valid |-> !done[result_i.rob]);

endmodule

// ==== rtl/reservation_station.sv ====
`timescale 1ns/1ns

module reservation_station
import core_cfg_pkg::*, uop_pkg::*;
(
    input  logic            clk,
    input  logic            rst,
    input  logic            dispatch_valid_i,
    input  renamed_uop_t    dispatch_i,
    output logic            rs_alloc_ok_o,
    input  logic [1:0]      src_ready_i,
    input  word_t [1:0]     src_value_i,
    output phys_reg_t [1:0] src_sel_o,
    input  result_t         result_i,
    input  logic            simple_ok_i,
    output logic            issue_valid_o,
    output issue_t          issue_o
);

    typedef struct packed {
        renamed_uop_t uop;
        logic [1:0]   rdy;
        word_t [1:0]  val;   // captured operands
    } rs_entry_t;

    rs_entry_t ent_q [RS_DEPTH];   // index 0 is oldest
    rs_entry_t ent_d [RS_DEPTH];
    rs_entry_t upd   [RS_DEPTH];
    rs_cnt_t   cnt_q;
    rs_cnt_t   cnt_d;
    rs_idx_t   pick;
    rs_entry_t sel;

    logic [PHYS_REGS-1:0] pending;   // producer dispatched, result not yet seen

    // physical 0 is never a real producer
    function automatic logic hit(result_t res, phys_reg_t ps);
        return res.valid && ps != '0 && res.pd == ps;
    endfunction

    assign rs_alloc_ok_o = cnt_q != rs_cnt_t'(RS_DEPTH);
    assign src_sel_o[0]  = dispatch_i.ps1;
    assign src_sel_o[1]  = dispatch_i.ps2;

    always_comb begin
        issue_valid_o = 1'b0;
        pick          = '0;
        for (int i = RS_DEPTH - 1; i >= 0; i--) begin
            if (rs_cnt_t'(i) < cnt_q && (&ent_q[i].rdy)
                && (ent_q[i].uop.opcode == OP_MUL || simple_ok_i)) begin
                issue_valid_o = 1'b1;
                pick          = rs_idx_t'(i);
            end
        end
    end

    assign sel            = ent_q[pick];
    assign issue_o.opcode = sel.uop.opcode;
    assign issue_o.op_a   = sel.val[0];
    assign issue_o.op_b   = (sel.uop.opcode == OP_ADDI) ? sel.uop.imm : sel.val[1];
    assign issue_o.pd     = sel.uop.pd;
    assign issue_o.rob    = sel.uop.rob;

    always_comb begin
        for (int i = 0; i < RS_DEPTH; i++) begin
            upd[i] = ent_q[i];
            if (!upd[i].rdy[0] && hit(result_i, upd[i].uop.ps1)) begin   // wakeup
                upd[i].rdy[0] = 1'b1;
                upd[i].val[0] = result_i.value;
            end
            if (!upd[i].rdy[1] && hit(result_i, upd[i].uop.ps2)) begin
                upd[i].rdy[1] = 1'b1;
                upd[i].val[1] = result_i.value;
            end
        end
        ent_d = upd;
        // close the gap behind the issued entry
        for (int i = 0; i < RS_DEPTH - 1; i++) begin
            if (issue_valid_o && i >= int'(pick)) begin
                ent_d[i] = upd[i + 1];
            end
        end
        cnt_d = cnt_q - rs_cnt_t'(issue_valid_o);
        if (dispatch_valid_i) begin
            ent_d[rs_idx_t'(cnt_d)].uop    = dispatch_i;
            ent_d[rs_idx_t'(cnt_d)].rdy[0] = src_ready_i[0] || hit(result_i, dispatch_i.ps1);
            ent_d[rs_idx_t'(cnt_d)].rdy[1] = src_ready_i[1] || hit(result_i, dispatch_i.ps2);
            ent_d[rs_idx_t'(cnt_d)].val[0] = hit(result_i, dispatch_i.ps1) ?
                                             result_i.value : src_value_i[0];
            ent_d[rs_idx_t'(cnt_d)].val[1] = hit(result_i, dispatch_i.ps2) ?
                                             result_i.value : src_value_i[1];
            cnt_d = cnt_d + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        ent_q <= ent_d;
        if (rst) begin
            cnt_q <= '0;
        end else begin
            cnt_q <= cnt_d;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pending <= '0;
        end else begin
            if (dispatch_valid_i && dispatch_i.pd != '0) begin
                pending[dispatch_i.pd] <= 1'b1;
            end
            if (result_i.valid) begin
                pending[result_i.pd] <= 1'b0;
            end
        end
    end

    a_issue_only_ready: assert property (@(posedge clk) disable iff (rst)
        issue_valid_o |-> !pending[sel.uop.ps1] && !pending[sel.uop.ps2]);

endmodule

// ==== rtl/uop_pkg.sv ====
package uop_pkg;
    import core_cfg_pkg::*;

    typedef enum logic [2:0] {
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_ADDI,
        OP_MUL
    } opcode_e;

    // decoded uop as it arrives from upstream
    typedef struct packed {
        opcode_e   opcode;
        arch_reg_t rd;
        arch_reg_t rs1;
        arch_reg_t rs2;
        word_t     imm;
    } uop_t;

    typedef struct packed {
        opcode_e   opcode;
        phys_reg_t pd;
        phys_reg_t ps1;
        phys_reg_t ps2;
        word_t     imm;
        rob_idx_t  rob;
    } renamed_uop_t;

    typedef struct packed {
        opcode_e   opcode;
        word_t     op_a;
        word_t     op_b;   // already holds imm for addi
        phys_reg_t pd;
        rob_idx_t  rob;
    } issue_t;

    typedef struct packed {
        logic      valid;
        phys_reg_t pd;
        rob_idx_t  rob;
        word_t     value;
    } result_t;

    typedef struct packed {
        logic      valid;
        arch_reg_t rd;
        word_t     value;
    } commit_t;

endpackage

// ==== verilog.f ====
+incdir+bench
rtl/core_cfg_pkg.sv
rtl/uop_pkg.sv
rtl/rename_unit.sv
rtl/reservation_station.sv
rtl/phys_regfile.sv
rtl/exec_unit.sv
rtl/reorder_buffer.sv
rtl/ooo_core.sv
bench/tb_ooo_core.sv
